//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_linear_array_top
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- rtl/linear_array_top.sv
module linear_array_top (
  input  logic                                                           clk,
  input  logic                                                           INTERNAL_RESET,

  // Activations
  input  pla_pkg::operand_t [pla_pkg::pe_rows*pla_pkg::batch_size-1:0]   l_data,
  input  logic              [pla_pkg::pe_rows*pla_pkg::batch_size-1:0]   l_valid,
  input  logic              [pla_pkg::pe_rows*pla_pkg::batch_size-1:0]   l_last,
  output logic              [pla_pkg::pe_rows*pla_pkg::batch_size-1:0]   l_ready,

  // Weights
  input  pla_pkg::operand_t [pla_pkg::pe_cols*pla_pkg::pe_rows-1:0]      t_data,
  input  logic              [pla_pkg::pe_cols*pla_pkg::pe_rows-1:0]      t_valid,
  input  logic              [pla_pkg::pe_cols*pla_pkg::pe_rows-1:0]      t_last,
  output logic              [pla_pkg::pe_cols*pla_pkg::pe_rows-1:0]      t_ready,

  // Results
  output pla_pkg::result_t  [pla_pkg::pe_cols*pla_pkg::batch_size-1:0]   d_data,
  output logic              [pla_pkg::pe_cols*pla_pkg::batch_size-1:0]   d_valid,
  output logic              [pla_pkg::pe_cols*pla_pkg::batch_size-1:0]   d_last,
  input  logic              [pla_pkg::pe_cols*pla_pkg::batch_size-1:0]   d_ready,

  output logic                                                           core_rst,
  output logic                                                           err_unaligned_data
);

  // Stretched core reset, also raised by a misaligned frame
  reset_sequencer u_reset_seq (
    .clk                (clk),
    .INTERNAL_RESET     (INTERNAL_RESET),
    .err_unaligned_data (err_unaligned_data),
    .core_rst           (core_rst)
  );

  linear_processing_array u_array (
    .clk                (clk),
    .core_rst           (core_rst),
    .l_data             (l_data),
    .l_valid            (l_valid),
    .l_last             (l_last),
    .l_ready            (l_ready),
    .t_data             (t_data),
    .t_valid            (t_valid),
    .t_last             (t_last),
    .t_ready            (t_ready),
    .d_data             (d_data),
    .d_valid            (d_valid),
    .d_last             (d_last),
    .d_ready            (d_ready),
    .err_unaligned_data (err_unaligned_data)
  );

endmodule

//--- rtl/linear_processing_array.sv
module linear_processing_array (
  input  logic                                                           clk,
  input  logic                                                           core_rst,

  // Activations, lane k*pe_rows + j
  input  pla_pkg::operand_t [pla_pkg::pe_rows*pla_pkg::batch_size-1:0]   l_data,
  input  logic              [pla_pkg::pe_rows*pla_pkg::batch_size-1:0]   l_valid,
  input  logic              [pla_pkg::pe_rows*pla_pkg::batch_size-1:0]   l_last,
  output logic              [pla_pkg::pe_rows*pla_pkg::batch_size-1:0]   l_ready,

  // Weights, lane j*pe_cols + i
  input  pla_pkg::operand_t [pla_pkg::pe_cols*pla_pkg::pe_rows-1:0]      t_data,
  input  logic              [pla_pkg::pe_cols*pla_pkg::pe_rows-1:0]      t_valid,
  input  logic              [pla_pkg::pe_cols*pla_pkg::pe_rows-1:0]      t_last,
  output logic              [pla_pkg::pe_cols*pla_pkg::pe_rows-1:0]      t_ready,

  // Results, lane k*pe_cols + i
  output pla_pkg::result_t  [pla_pkg::pe_cols*pla_pkg::batch_size-1:0]   d_data,
  output logic              [pla_pkg::pe_cols*pla_pkg::batch_size-1:0]   d_valid,
  output logic              [pla_pkg::pe_cols*pla_pkg::batch_size-1:0]   d_last,
  input  logic              [pla_pkg::pe_cols*pla_pkg::batch_size-1:0]   d_ready,

  output logic                                                           err_unaligned_data
);

  // Activation nodes, one extra column for the right edge
  pla_pkg::operand_t lr_data  [(pla_pkg::pe_cols+1)*pla_pkg::pe_rows*pla_pkg::batch_size];
  logic              lr_valid [(pla_pkg::pe_cols+1)*pla_pkg::pe_rows*pla_pkg::batch_size];
  logic              lr_last  [(pla_pkg::pe_cols+1)*pla_pkg::pe_rows*pla_pkg::batch_size];
  logic              lr_ready [(pla_pkg::pe_cols+1)*pla_pkg::pe_rows*pla_pkg::batch_size];

  // Weight nodes, one extra plane past the last batch
  pla_pkg::operand_t tb_data  [pla_pkg::pe_cols*pla_pkg::pe_rows*(pla_pkg::batch_size+1)];
  logic              tb_valid [pla_pkg::pe_cols*pla_pkg::pe_rows*(pla_pkg::batch_size+1)];
  logic              tb_last  [pla_pkg::pe_cols*pla_pkg::pe_rows*(pla_pkg::batch_size+1)];
  logic              tb_ready [pla_pkg::pe_cols*pla_pkg::pe_rows*(pla_pkg::batch_size+1)];

  // Partial sum nodes, one extra row at the bottom
  pla_pkg::psum_t    ud_data  [pla_pkg::pe_cols*(pla_pkg::pe_rows+1)*pla_pkg::batch_size];
  logic              ud_valid [pla_pkg::pe_cols*(pla_pkg::pe_rows+1)*pla_pkg::batch_size];
  logic              ud_last  [pla_pkg::pe_cols*(pla_pkg::pe_rows+1)*pla_pkg::batch_size];
  logic              ud_ready [pla_pkg::pe_cols*(pla_pkg::pe_rows+1)*pla_pkg::batch_size];

  logic [pla_pkg::pe_cols*pla_pkg::pe_rows*pla_pkg::batch_size-1:0] pe_err;

  // Any PE out of step flags the whole array
  assign err_unaligned_data = |pe_err;

  genvar gk, gj, gi;

  generate
    for (gk = 0; gk < pla_pkg::batch_size; gk++) begin : g_plane
      for (gj = 0; gj < pla_pkg::pe_rows; gj++) begin : g_row
        for (gi = 0; gi < pla_pkg::pe_cols; gi++) begin : g_col
          localparam int uid    = (gk * pla_pkg::pe_rows + gj) * pla_pkg::pe_cols + gi;
          localparam int node_l = (gk * pla_pkg::pe_rows + gj) * (pla_pkg::pe_cols + 1) + gi;
          localparam int node_r = node_l + 1;
          localparam int node_t = (gk * pla_pkg::pe_rows + gj) * pla_pkg::pe_cols + gi;
          localparam int node_b = ((gk + 1) * pla_pkg::pe_rows + gj) * pla_pkg::pe_cols + gi;
          localparam int node_u = (gk * (pla_pkg::pe_rows + 1) + gj) * pla_pkg::pe_cols + gi;
          localparam int node_d = node_u + pla_pkg::pe_cols;

          mac_pe u_pe (
            .clk                (clk),
            .INTERNAL_RESET     (core_rst),
            .l_data             (lr_data[node_l]),
            .l_valid            (lr_valid[node_l]),
            .l_last             (lr_last[node_l]),
            .l_ready            (lr_ready[node_l]),
            .t_data             (tb_data[node_t]),
            .t_valid            (tb_valid[node_t]),
            .t_last             (tb_last[node_t]),
            .t_ready            (tb_ready[node_t]),
            .u_data             (ud_data[node_u]),
            .u_valid            (ud_valid[node_u]),
            .u_last             (ud_last[node_u]),
            .u_ready            (ud_ready[node_u]),
            .r_data             (lr_data[node_r]),
            .r_valid            (lr_valid[node_r]),
            .r_last             (lr_last[node_r]),
            .r_ready            (lr_ready[node_r]),
            .b_data             (tb_data[node_b]),
            .b_valid            (tb_valid[node_b]),
            .b_last             (tb_last[node_b]),
            .b_ready            (tb_ready[node_b]),
            .d_data             (ud_data[node_d]),
            .d_valid            (ud_valid[node_d]),
            .d_last             (ud_last[node_d]),
            .d_ready            (ud_ready[node_d]),
            .err_unaligned_data (pe_err[uid])
          );

          if (gi == 0) begin : g_left
            localparam int lane = gk * pla_pkg::pe_rows + gj;
            assign lr_data[node_l]  = l_data[lane];
            assign lr_valid[node_l] = l_valid[lane];
            assign lr_last[node_l]  = l_last[lane];
            assign l_ready[lane]    = lr_ready[node_l];
          end

          // Activations leaving the right edge are dropped
          if (gi == pla_pkg::pe_cols - 1) begin : g_right
            assign lr_ready[node_r] = 1'b1;
          end

          if (gk == 0) begin : g_top
            localparam int lane = gj * pla_pkg::pe_cols + gi;
            assign tb_data[node_t]  = t_data[lane];
            assign tb_valid[node_t] = t_valid[lane];
            assign tb_last[node_t]  = t_last[lane];
            assign t_ready[lane]    = tb_ready[node_t];
          end

          // Weights past the last plane are dropped
          if (gk == pla_pkg::batch_size - 1) begin : g_bottom
            assign tb_ready[node_b] = 1'b1;
          end

          // First row starts every column from zero
          if (gj == 0) begin : g_up
            assign ud_data[node_u]  = '0;
            assign ud_valid[node_u] = 1'b1;
            assign ud_last[node_u]  = 1'b0;
          end

          // Truncate the final sum back to Q4.12
          if (gj == pla_pkg::pe_rows - 1) begin : g_down
            localparam int lane = gk * pla_pkg::pe_cols + gi;
            assign d_data[lane]     = ud_data[node_d][pla_pkg::rslt_lsb +: pla_pkg::rslt_width];
            assign d_valid[lane]    = ud_valid[node_d];
            assign d_last[lane]     = ud_last[node_d];
            assign ud_ready[node_d] = d_ready[lane];
          end
        end
      end
    end
  endgenerate

endmodule

//--- rtl/mac_pe.sv
module mac_pe (
  input  logic              clk,
  input  logic              INTERNAL_RESET,

  // Activation from the left
  input  pla_pkg::operand_t l_data,
  input  logic              l_valid,
  input  logic              l_last,
  output logic              l_ready,

  // Weight from the plane above
  input  pla_pkg::operand_t t_data,
  input  logic              t_valid,
  input  logic              t_last,
  output logic              t_ready,

  // Partial sum from the row above
  input  pla_pkg::psum_t    u_data,
  input  logic              u_valid,
  input  logic              u_last,
  output logic              u_ready,

  // Activation to the right
  output pla_pkg::operand_t r_data,
  output logic              r_valid,
  output logic              r_last,
  input  logic              r_ready,

  // Weight to the next plane
  output pla_pkg::operand_t b_data,
  output logic              b_valid,
  output logic              b_last,
  input  logic              b_ready,

  // Partial sum to the row below
  output pla_pkg::psum_t    d_data,
  output logic              d_valid,
  output logic              d_last,
  input  logic              d_ready,

  output logic              err_unaligned_data
);

  logic                                  r_free;
  logic                                  b_free;
  logic                                  d_free;
  logic                                  fire;
  logic signed [2*pla_pkg::op_width-1:0] product;

  // An output slot is free when empty or drained in this cycle
  assign r_free = ~r_valid | r_ready;
  assign b_free = ~b_valid | b_ready;
  assign d_free = ~d_valid | d_ready;

  // Fire only with a full input set and room on every output
  assign fire = ~INTERNAL_RESET & l_valid & t_valid & u_valid & r_free & b_free & d_free;

  // All three inputs are consumed together
  assign l_ready = fire;
  assign t_ready = fire;
  assign u_ready = fire;

  assign product = l_data * t_data;

  // Valid flags and sticky error
  always_ff @(posedge clk) begin
    if (INTERNAL_RESET) begin
      r_valid            <= 1'b0;
      b_valid            <= 1'b0;
      d_valid            <= 1'b0;
      err_unaligned_data <= 1'b0;
    end else begin
      if (fire) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end

      if (fire) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end

      if (fire) begin
        d_valid <= 1'b1;
      end else if (d_ready) begin
        d_valid <= 1'b0;
      end

      // Activation and weight belong to different frames
      if (fire && (l_last != t_last)) begin
        err_unaligned_data <= 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (fire) begin
      r_data <= l_data;
      r_last <= l_last;
      b_data <= t_data;
      b_last <= t_last;
      d_data <= u_data + product;
      d_last <= l_last;
    end
  end

  // A stalled partial sum must not change before the row below takes it
  a_d_hold: assert property (@(posedge clk) disable iff (INTERNAL_RESET)
    d_valid && !d_ready |=> d_valid && $stable(d_data));

  // Reset empties all three output slots
  a_rst_empty: assert property (@(posedge clk)
    INTERNAL_RESET |=> !(r_valid || b_valid || d_valid));

endmodule

//--- rtl/pla_pkg.sv
package pla_pkg;

  // Array dimensions
  localparam int pe_cols    = 2;
  localparam int pe_rows    = 2;
  localparam int batch_size = 2;

  // Q4.12 operands
  localparam int op_width = 16;
  localparam int op_frac  = 12;

  // Wide accumulator so a column of products cannot overflow
  localparam int psum_width = 48;

  // Q4.12 results
  localparam int rslt_width = 16;
  localparam int rslt_frac  = 12;

  // Product of two Q4.12 values carries 2*op_frac fraction bits
  localparam int rslt_lsb = 2 * op_frac - rslt_frac;

  // Reset control
  localparam bit reset_on_error = 1'b1;
  localparam int reset_stretch  = 3;

  // Signed Q4.12 activation or weight
  typedef logic signed [op_width-1:0] operand_t;

  // Signed partial sum, 24 fraction bits
  typedef logic signed [psum_width-1:0] psum_t;

  // Signed Q4.12 result
  typedef logic signed [rslt_width-1:0] result_t;

endpackage

//--- rtl/reset_sequencer.sv
module reset_sequencer (
  input  logic clk,
  input  logic INTERNAL_RESET,
  input  logic err_unaligned_data,
  output logic core_rst
);

  logic                              rst_src;
  logic [pla_pkg::reset_stretch-1:0] stretch_q;

  // Alignment error restarts the core only when enabled
  assign rst_src = INTERNAL_RESET | (err_unaligned_data & pla_pkg::reset_on_error);

  // Shift the source through the stretch stages
  always_ff @(posedge clk) begin
    stretch_q <= {stretch_q[pla_pkg::reset_stretch-2:0], rst_src};
  end

  // High with the source and until the last stage drains
  assign core_rst = rst_src | (|stretch_q);

  a_rst_follows: assert property (@(posedge clk) INTERNAL_RESET |=> core_rst);

endmodule

//--- sources.f
+incdir+testbench
rtl/pla_pkg.sv
rtl/mac_pe.sv
rtl/reset_sequencer.sv
rtl/linear_processing_array.sv
rtl/linear_array_top.sv
testbench/tb_linear_array_top.sv

//--- testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: name, activations on lane k*2+j, weights on lane j*2+i, last, misalign
// Results on lane k*2+i are the Q4.12 sum over j of act(j,k) * wt(i,j), truncated

localparam int vec_rows       = 7;
localparam int clean_rows     = 5;
localparam int misaligned_row = 5;
localparam int recovery_row   = 6;

string       vec_name     [vec_rows];
logic [15:0] vec_act      [vec_rows][lanes];
logic [15:0] vec_wt       [vec_rows][lanes];
logic [15:0] vec_rslt     [vec_rows][lanes];
logic        vec_last     [vec_rows];
logic        vec_misalign [vec_rows];

task automatic set_flags(input int n, input string name, input bit last, input bit misalign);
  vec_name[n]     = name;
  vec_last[n]     = last;
  vec_misalign[n] = misalign;
endtask

task automatic load_vectors();
  // Identity weights, unit activations
  set_flags(0, "ident_unit", 1'b0, 1'b0);
  vec_act[0]  = '{16'h1000, 16'h1000, 16'h1000, 16'h1000};
  vec_wt[0]   = '{16'h1000, 16'h0000, 16'h0000, 16'h1000};
  vec_rslt[0] = '{16'h1000, 16'h1000, 16'h1000, 16'h1000};
  // Identity weights pass each activation through
  set_flags(1, "ident_act", 1'b1, 1'b0);
  vec_act[1]  = '{16'h0800, 16'h0400, 16'hf000, 16'h2000};
  vec_wt[1]   = '{16'h1000, 16'h0000, 16'h0000, 16'h1000};
  vec_rslt[1] = '{16'h0800, 16'h0400, 16'hf000, 16'h2000};
  // -1.0 + -0.25 and 0.5 + 1.5
  set_flags(2, "neg_weights", 1'b0, 1'b0);
  vec_act[2]  = '{16'h1000, 16'h1000, 16'h1000, 16'h1000};
  vec_wt[2]   = '{16'hf000, 16'h0800, 16'hfc00, 16'h1800};
  vec_rslt[2] = '{16'hec00, 16'h2000, 16'hec00, 16'h2000};
  // 2.5, -2.75, 1.625 and 0.125
  set_flags(3, "mixed", 1'b1, 1'b0);
  vec_act[3]  = '{16'h1800, 16'he000, 16'h0c00, 16'h0800};
  vec_wt[3]   = '{16'h2000, 16'hf800, 16'h0400, 16'h1000};
  vec_rslt[3] = '{16'h2800, 16'hd400, 16'h1a00, 16'h0200};
  // Fractions below one LSB round toward minus infinity
  set_flags(4, "truncation", 1'b0, 1'b0);
  vec_act[4]  = '{16'h0001, 16'h0002, 16'hffff, 16'h0000};
  vec_wt[4]   = '{16'h0800, 16'h1000, 16'h0800, 16'h0000};
  vec_rslt[4] = '{16'h0001, 16'h0001, 16'hffff, 16'hffff};
  set_flags(5, "misaligned", 1'b1, 1'b1);
  vec_act[5]  = '{16'h1000, 16'h1000, 16'h1000, 16'h1000};
  vec_wt[5]   = '{16'h1000, 16'h0000, 16'h0000, 16'h1000};
  vec_rslt[5] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000};
  // 1.0, -1.0, -0.25 and 4.0
  set_flags(6, "recovery", 1'b1, 1'b0);
  vec_act[6]  = '{16'h1000, 16'h1000, 16'h2000, 16'hf000};
  vec_wt[6]   = '{16'h0400, 16'h1000, 16'h0c00, 16'he000};
  vec_rslt[6] = '{16'h1000, 16'hf000, 16'hfc00, 16'h4000};
endtask

`endif

//--- testbench/tb_linear_array_top.sv
module tb_linear_array_top;

  localparam int lanes          = 4;
  localparam int half_period    = 4;
  localparam int reset_cycles   = 16;
  localparam int stretch_cycles = 3;

  `include "tb_vectors.svh"

  // Clean rows run alone, streamed and under back-pressure, plus the error pair
  localparam int applied_rows    = 3 * clean_rows + 2;
  localparam int watchdog_cycles = applied_rows * 40 + 200;

  logic                          clk;
  logic                          INTERNAL_RESET;
  pla_pkg::operand_t [lanes-1:0] l_data;
  logic [lanes-1:0]              l_valid;
  logic [lanes-1:0]              l_last;
  logic [lanes-1:0]              l_ready;
  pla_pkg::operand_t [lanes-1:0] t_data;
  logic [lanes-1:0]              t_valid;
  logic [lanes-1:0]              t_last;
  logic [lanes-1:0]              t_ready;
  pla_pkg::result_t  [lanes-1:0] d_data;
  logic [lanes-1:0]              d_valid;
  logic [lanes-1:0]              d_last;
  logic [lanes-1:0]              d_ready;
  logic                          core_rst;
  logic                          err_unaligned_data;

  integer seed;
  int     n_checks;
  int     n_errors;

  linear_array_top i_dut (
    .clk                (clk),
    .INTERNAL_RESET     (INTERNAL_RESET),
    .l_data             (l_data),
    .l_valid            (l_valid),
    .l_last             (l_last),
    .l_ready            (l_ready),
    .t_data             (t_data),
    .t_valid            (t_valid),
    .t_last             (t_last),
    .t_ready            (t_ready),
    .d_data             (d_data),
    .d_valid            (d_valid),
    .d_last             (d_last),
    .d_ready            (d_ready),
    .core_rst           (core_rst),
    .err_unaligned_data (err_unaligned_data)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic report_test(input string name, input int errors_before);
    if (n_errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n_errors - errors_before);
    end
  endtask

  task automatic check_reset();
    int high_cycles;
    high_cycles = 0;
    // Offer a full input set that the held core must refuse
    l_valid = '1;
    t_valid = '1;
    repeat (reset_cycles) begin
      @(negedge clk);
      n_checks++;
      if (core_rst !== 1'b1 || d_valid !== '0 || err_unaligned_data !== 1'b0 ||
          l_ready !== '0 || t_ready !== '0) begin
        $display("FAIL reset: core_rst low or an output active while reset is applied");
        n_errors++;
      end
    end
    INTERNAL_RESET = 1'b0;
    #1;
    // Count the cycles that core_rst outlives the reset input
    while (core_rst && high_cycles <= 2 * stretch_cycles) begin
      n_checks++;
      if (d_valid !== '0 || err_unaligned_data !== 1'b0 ||
          l_ready !== '0 || t_ready !== '0) begin
        $display("FAIL reset: output or ready active while core_rst is still high");
        n_errors++;
      end
      high_cycles++;
      @(negedge clk);
      #1;
    end
    // Withdrawn before the next rising edge, so nothing transfers
    l_valid = '0;
    t_valid = '0;
    n_checks++;
    if (high_cycles != stretch_cycles) begin
      $display("FAIL reset_stretch: expected %0d, actual %0d", stretch_cycles, high_cycles);
      n_errors++;
    end
  endtask

  task automatic run_rows(input string phase, input int first, input int count, input bit bp);
    int l_next [lanes];
    int t_next [lanes];
    int d_got  [lanes];
    int ln;
    int row;
    bit done;
    for (ln = 0; ln < lanes; ln++) begin
      l_next[ln] = 0;
      t_next[ln] = 0;
      d_got[ln]  = 0;
    end
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      // Each lane holds its row until it transfers
      for (ln = 0; ln < lanes; ln++) begin
        l_valid[ln] = (l_next[ln] < count);
        if (l_next[ln] < count) begin
          row        = first + l_next[ln];
          l_data[ln] = vec_act[row][ln];
          l_last[ln] = vec_last[row];
        end
        t_valid[ln] = (t_next[ln] < count);
        if (t_next[ln] < count) begin
          row        = first + t_next[ln];
          t_data[ln] = vec_wt[row][ln];
          t_last[ln] = vec_last[row] ^ vec_misalign[row];
        end
      end
      d_ready = bp ? lanes'($random(seed)) : '1;
      #1;
      done = 1'b1;
      for (ln = 0; ln < lanes; ln++) begin
        if (l_valid[ln] && l_ready[ln]) l_next[ln]++;
        if (t_valid[ln] && t_ready[ln]) t_next[ln]++;
        if (d_valid[ln] && d_ready[ln]) begin
          n_checks++;
          if (d_got[ln] >= count) begin
            $display("FAIL %s: extra result on lane %0d", phase, ln);
            n_errors++;
          end else begin
            row = first + d_got[ln];
            if (d_data[ln] !== vec_rslt[row][ln]) begin
              $display("FAIL %s/%s lane %0d data: expected %h, actual %h",
                       phase, vec_name[row], ln, vec_rslt[row][ln], d_data[ln]);
              n_errors++;
            end
            n_checks++;
            if (d_last[ln] !== vec_last[row]) begin
              $display("FAIL %s/%s lane %0d last: expected %b, actual %b",
                       phase, vec_name[row], ln, vec_last[row], d_last[ln]);
              n_errors++;
            end
            d_got[ln]++;
          end
        end
        if (d_got[ln] < count) done = 1'b0;
      end
    end
    // Nothing may follow the last expected result
    repeat (4) begin
      @(negedge clk);
      l_valid = '0;
      t_valid = '0;
      d_ready = '1;
      #1;
      n_checks++;
      if (d_valid != '0) begin
        $display("FAIL %s: result appeared after all expected results", phase);
        n_errors++;
      end
    end
  endtask

  task automatic run_misaligned(input int bad_row, input int good_row);
    int ln;
    int waited;
    bit cleared;
    @(negedge clk);
    d_ready = '1;
    for (ln = 0; ln < lanes; ln++) begin
      l_valid[ln] = 1'b1;
      l_data[ln]  = vec_act[bad_row][ln];
      l_last[ln]  = vec_last[bad_row];
      t_valid[ln] = 1'b1;
      t_data[ln]  = vec_wt[bad_row][ln];
      t_last[ln]  = vec_last[bad_row] ^ vec_misalign[bad_row];
    end
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!err_unaligned_data && waited < 20);
    n_checks += 2;
    if (!err_unaligned_data) begin
      $display("FAIL misalign: err_unaligned_data did not rise within 20 cycles");
      n_errors++;
    end
    if (!core_rst) begin
      $display("FAIL misalign: core_rst did not rise with the alignment error");
      n_errors++;
    end
    // Reset flushes the array, so the rest of the frame is dropped
    l_valid = '0;
    t_valid = '0;
    cleared = 1'b0;
    waited  = 0;
    while (core_rst && waited < 20) begin
      @(negedge clk);
      waited++;
      if (core_rst && !err_unaligned_data) cleared = 1'b1;
      n_checks++;
      if (core_rst && d_valid != '0) begin
        $display("FAIL misalign: d_valid high while core_rst is high");
        n_errors++;
      end
    end
    n_checks += 2;
    if (!cleared || err_unaligned_data) begin
      $display("FAIL misalign: err_unaligned_data was not cleared by core_rst");
      n_errors++;
    end
    if (core_rst) begin
      $display("FAIL misalign: core_rst stayed high after the error cleared");
      n_errors++;
    end
    run_rows("misalign", good_row, 1, 1'b0);
  endtask

  initial begin
    int errs;
    int row;
    seed           = 32'h58ae_e993;
    n_checks       = 0;
    n_errors       = 0;
    INTERNAL_RESET = 1'b1;
    l_data         = '0;
    l_valid        = '0;
    l_last         = '0;
    t_data         = '0;
    t_valid        = '0;
    t_last         = '0;
    d_ready        = '1;
    load_vectors();

    errs = n_errors;
    check_reset();
    report_test("reset", errs);

    for (row = 0; row < clean_rows; row++) begin
      errs = n_errors;
      run_rows("single", row, 1, 1'b0);
      report_test({"single_", vec_name[row]}, errs);
    end

    errs = n_errors;
    run_rows("stream", 0, clean_rows, 1'b0);
    report_test("stream", errs);

    errs = n_errors;
    run_rows("backpressure", 0, clean_rows, 1'b1);
    report_test("backpressure", errs);

    errs = n_errors;
    run_misaligned(misaligned_row, recovery_row);
    report_test("misalign", errs);

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
